//--- common/rvPkg.sv
package rvPkg;

    typedef logic [31:0] instrWord;    // One raw instruction
    typedef logic [31:0] dataWord;     // Register value, address or PC
    typedef logic [4:0]  regAddr;      // Register index

    // Major opcode, instruction bits 6 to 2
    typedef enum logic [4:0] {
        LOAD   = 5'b00000,    // Loads
        STORE  = 5'b01000,    // Stores
        OP_IMM = 5'b00100,    // Register-immediate ALU ops
        OP     = 5'b01100,    // Register-register ALU ops
        LUI    = 5'b01101,    // Load upper immediate
        AUIPC  = 5'b00101,    // Upper immediate plus PC
        BRANCH = 5'b11000,    // Not executed here
        JAL    = 5'b11011,
        JALR   = 5'b11001,
        SYSTEM = 5'b11100
    } opCode;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLT,     // Signed compare
        SLTU,    // Unsigned compare
        XOR,
        OR,
        AND,
        SLL,
        SRL,
        SRA      // Copies the sign bit in
    } aluCtrl;

    // Straight from funct3 bits 1 and 0
    typedef enum logic [1:0] {
        BITS8  = 2'b00,
        BITS16 = 2'b01,
        BITS32 = 2'b10,
        ERRVAL = 2'b11
    } lsWidth;

    typedef struct packed {
        opCode   op;
        aluCtrl  alu;
        regAddr  rs1;
        regAddr  rs2;
        regAddr  rd;
        dataWord imm;           // Already sign-extended
        logic    useImm;        // Immediate is operand b
        logic    regWrite;      // Never set for x0
        logic    isLoad;
        logic    isStore;
        logic    loadSigned;
        lsWidth  width;
        logic    illegal;
    } decodedInstr;

    typedef struct packed {
        regAddr  rd;
        dataWord data;
        logic    writeEn;
        logic    illegal;
    } retireInfo;

    localparam int      defaultQueueDepth = 4;
    localparam int      defaultRamWords   = 64;
    localparam dataWord defaultResetPc    = 32'h0000_0000;

endpackage

//--- execute/aluUnit.sv
`timescale 1ns/10ps

module aluUnit
(
    input  rvPkg::aluCtrl  ctrl,
    input  rvPkg::dataWord a,
    input  rvPkg::dataWord b,
    output rvPkg::dataWord result
);
    import rvPkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];    // Upper bits ignored

    always_comb
    begin
        case (ctrl)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLT:     result = dataWord'($signed(a) < $signed(b));
            SLTU:    result = dataWord'(a < b);
            XOR:     result = a ^ b;
            OR:      result = a | b;
            AND:     result = a & b;
            SLL:     result = a << shamt;
            SRL:     result = a >> shamt;
            SRA:     result = dataWord'($signed(a) >>> shamt);
            default: result = a + b;
        endcase
    end

endmodule

//--- execute/loadStoreUnit.sv
`timescale 1ns/10ps

module loadStoreUnit
#(
    parameter int RamWords = rvPkg::defaultRamWords
)
(
    input  logic           clk,
    input  logic           arstN,
    input  rvPkg::dataWord addr,
    input  rvPkg::dataWord storeData,
    input  logic           storeEn,
    input  logic           loadSigned,
    input  rvPkg::lsWidth  width,
    output rvPkg::dataWord loadData,
    output logic           misaligned
);
    import rvPkg::*;

    localparam int IdxBits = (RamWords > 1) ? $clog2(RamWords) : 1;

    dataWord            ram [RamWords];
    logic [IdxBits-1:0] wordIdx;
    logic [1:0]         byteOff;
    logic [3:0]         laneEn;
    dataWord            laneData;    // Store data copied onto every lane
    dataWord            rdWord;
    dataWord            shifted;

    assign byteOff = addr[1:0];
    assign wordIdx = IdxBits'(addr[31:2] % RamWords);    // Wraps around the RAM

    always_comb
    begin
        case (width)
            BITS16:  misaligned = byteOff[0];
            BITS32:  misaligned = (byteOff != 2'b00);
            default: misaligned = 1'b0;
        endcase
    end

    always_comb
    begin
        case (width)
            BITS8:
            begin
                laneEn   = 4'b0001 << byteOff;
                laneData = {4{storeData[7:0]}};
            end
            BITS16:
            begin
                laneEn   = 4'b0011 << {byteOff[1], 1'b0};
                laneData = {2{storeData[15:0]}};
            end
            default:
            begin
                laneEn   = 4'b1111;
                laneData = storeData;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < RamWords; i++)
                ram[i] <= '0;
        end
        else if (storeEn && !misaligned)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (laneEn[b])
                    ram[wordIdx][8*b +: 8] <= laneData[8*b +: 8];
            end
        end
    end

    assign rdWord  = ram[wordIdx];
    assign shifted = rdWord >> {byteOff, 3'b000};    // Selected lane to bit 0

    always_comb
    begin
        case (width)
            BITS8:   loadData = {{24{loadSigned & shifted[7]}}, shifted[7:0]};
            BITS16:  loadData = {{16{loadSigned & shifted[15]}}, shifted[15:0]};
            default: loadData = rdWord;
        endcase
    end

endmodule

//--- filelist.f
common/rvPkg.sv
verilog/instrDecoder.sv
verilog/instrQueue.sv
verilog/regFile.sv
execute/aluUnit.sv
execute/loadStoreUnit.sv
verilog/rvExecCore.sv
sim/rvExecCore_properties.sv
sim/rvExecCore_tb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rvExecCore_tb \
    -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VrvExecCore_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    exit 1
fi
if ! grep -q "sim passed" sim.log; then
    echo "Simulation log has no pass message"
    exit 1
fi
exit 0

//--- sim/rvExecCore_properties.sv
`timescale 1ns/10ps

module rvExecCore_properties
#(
    parameter int QueueDepth = rvPkg::defaultQueueDepth
)
(
    input logic             clk,
    input logic             arstN,
    input logic             instrValid,
    input logic             notEmpty,
    input logic             creditReturn,
    input logic             retireValid,
    input rvPkg::retireInfo retire
);
    import rvPkg::*;

    int occupancy;    // Mirrors the queue fill from push and pop

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            occupancy <= 0;
        else
            occupancy <= occupancy + int'(instrValid) - int'(notEmpty);
    end

    noOverflow: assert property (@(posedge clk) disable iff (!arstN)
        instrValid |-> (occupancy < QueueDepth))
        else $error("Instruction pushed into a full queue");

    quietInReset: assert property (@(posedge clk)
        !arstN |-> (!retireValid && !creditReturn))
        else $error("Retire or credit active during reset");

    noWriteWhenIllegal: assert property (@(posedge clk) disable iff (!arstN)
        retireValid |-> !(retire.writeEn && retire.illegal))
        else $error("Retire record both writes and is illegal");

    noWriteToX0: assert property (@(posedge clk) disable iff (!arstN)
        (retireValid && (retire.rd == '0)) |-> !retire.writeEn)
        else $error("Retire record writes x0");

endmodule

bind rvExecCore rvExecCore_properties #(.QueueDepth(QueueDepth)) i_properties
(
    .clk          (clk),
    .arstN        (arstN),
    .instrValid   (instrValid),
    .notEmpty     (notEmpty),
    .creditReturn (creditReturn),
    .retireValid  (retireValid),
    .retire       (retire)
);

//--- sim/rvExecCore_tb.sv
`timescale 1ns/10ps

module rvExecCore_tb;
    import rvPkg::*;

    localparam logic [4:0] opLoad  = 5'b00000;
    localparam logic [4:0] opStore = 5'b01000;
    localparam logic [4:0] opImm   = 5'b00100;
    localparam logic [4:0] opReg   = 5'b01100;
    localparam logic [4:0] opLui   = 5'b01101;
    localparam logic [4:0] opAuipc = 5'b00101;

    logic      clk;
    logic      arstN;
    logic      instrValid;
    instrWord  instrData;
    logic      creditReturn;
    logic      retireValid;
    retireInfo retire;

    int       seed;
    int       errors;
    int       credits;         // Source side credit counter
    int       pushes;
    int       retired;
    int       creditPulses;
    instrWord pending[$];      // Pushed but not yet retired
    dataWord  regs [32];       // Reference architectural state
    dataWord  ram [defaultRamWords];
    dataWord  pc;

    rvExecCore i_dut
    (
        .clk          (clk),
        .arstN        (arstN),
        .instrValid   (instrValid),
        .instrData    (instrData),
        .creditReturn (creditReturn),
        .retireValid  (retireValid),
        .retire       (retire)
    );

    always #20 clk = ~clk;

    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic instrWord encR(input logic alt, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
        return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, opReg, 2'b11};
    endfunction

    function automatic instrWord encI(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [4:0] op);
        return {imm, rs1, f3, rd, op, 2'b11};
    endfunction

    function automatic instrWord encS(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore, 2'b11};
    endfunction

    function automatic instrWord encU(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [4:0] op);
        return {imm, rd, op, 2'b11};
    endfunction

    // RAM offset that is mostly aligned to the width
    function automatic logic [11:0] memOffset(input logic [1:0] width);
        logic [11:0] off;
        off = 12'(pick(64) * 4);
        if (width == 2'b00)
            off[1:0] = 2'(pick(4));
        else if (width == 2'b01)
            off[1] = 1'(pick(2));
        if (pick(8) == 0)
            off[1:0] = 2'(pick(4));
        return off;
    endfunction

    function automatic instrWord genInstr();
        int unsigned kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  base;
        logic [2:0]  f3;
        logic [31:0] r;
        kind = pick(16);
        rd   = 5'(pick(8));
        rs1  = 5'(pick(8));
        base = (pick(4) != 0) ? 5'd0 : rs1;    // Mostly x0 so loads hit stores
        f3   = 3'(pick(8));
        r    = $random(seed);
        case (kind)
            0, 1, 2, 3, 4:
                return encR(r[0], 5'(pick(8)), rs1, f3, rd);
            5, 6, 7, 14:
                return encI(r[11:0], rs1, f3, rd, opImm);
            8:
                return encU(r[31:12], rd, r[0] ? opLui : opAuipc);
            9, 10:
            begin
                if (pick(8) != 0)
                    f3 = 3'(pick(3));
                return encS(memOffset(f3[1:0]), 5'(pick(8)), base, f3);
            end
            11, 12, 13:
            begin
                if (pick(8) != 0)
                begin
                    f3 = 3'(pick(3));
                    f3[2] = (f3 != 3'b010) && (pick(2) == 1);    // LBU or LHU
                end
                return encI(memOffset(f3[1:0]), base, f3, rd, opLoad);
            end
            default:
            begin
                case (pick(6))
                    0:       return {r[31:7], 5'b11000, 2'b11};    // Branch
                    1:       return {r[31:7], 5'b11011, 2'b11};    // Jal
                    2:       return {r[31:7], 5'b11001, 2'b11};    // Jalr
                    3:       return {r[31:7], 5'b11100, 2'b11};    // System
                    4:       return {r[31:7], 5'b10110, 2'b11};    // Unknown
                    default: return {r[31:2], 2'b01};              // Compressed space
                endcase
            end
        endcase
    endfunction

    function automatic dataWord aluModel(input logic [2:0] f3, input logic alt,
                                         input dataWord a, input dataWord b);
        logic signed [31:0] sa;
        dataWord            sraVal;
        sa     = a;
        sraVal = sa >>> b[4:0];
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? sraVal : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic misalignedModel(input logic [1:0] width, input dataWord addr);
        return ((width == 2'b01) && addr[0]) || ((width == 2'b10) && (addr[1:0] != 2'b00));
    endfunction

    function automatic string instrKind(input instrWord w);
        if (w[1:0] != 2'b11)
            return "illegal";
        case (w[6:2])
            opReg:          return "alu reg";
            opImm:          return "alu imm";
            opLui, opAuipc: return "upper imm";
            opLoad:         return "load";
            opStore:        return "store";
            default:        return "illegal";
        endcase
    endfunction

    // Executes one instruction on the reference state
    task automatic modelExecute(input instrWord w, output retireInfo want);
        logic [2:0] f3;
        dataWord    a;
        dataWord    b;
        dataWord    addr;
        dataWord    lane;
        int         idx;
        f3   = w[14:12];
        a    = regs[w[19:15]];
        b    = regs[w[24:20]];
        want = '0;
        want.rd = w[11:7];
        if (w[1:0] != 2'b11)
            want.illegal = 1'b1;
        else
        begin
            case (w[6:2])
                opReg, opImm:
                begin
                    if (w[6:2] == opReg)
                        want.data = aluModel(f3, w[30], a, b);
                    else
                        want.data = aluModel(f3, w[30] && (f3 == 3'b101),
                                             a, {{20{w[31]}}, w[31:20]});
                    want.writeEn = 1'b1;
                end
                opLui, opAuipc:
                begin
                    want.data    = {w[31:12], 12'h000} +
                                   ((w[6:2] == opAuipc) ? pc : 32'd0);
                    want.writeEn = 1'b1;
                end
                opLoad:
                begin
                    addr = a + {{20{w[31]}}, w[31:20]};
                    idx  = int'(addr[31:2] % defaultRamWords);
                    lane = ram[idx] >> (8 * addr[1:0]);
                    want.illegal = (f3[1:0] == 2'b11) || (f3 == 3'b110) ||
                                   misalignedModel(f3[1:0], addr);
                    case (f3[1:0])
                        2'b00:   want.data = {{24{lane[7] & ~f3[2]}}, lane[7:0]};
                        2'b01:   want.data = {{16{lane[15] & ~f3[2]}}, lane[15:0]};
                        default: want.data = lane;
                    endcase
                    want.writeEn = 1'b1;
                end
                opStore:
                begin
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    idx  = int'(addr[31:2] % defaultRamWords);
                    want.illegal = f3[2] || (f3[1:0] == 2'b11) ||
                                   misalignedModel(f3[1:0], addr);
                    if (!want.illegal)
                    begin
                        case (f3[1:0])
                            2'b00:   ram[idx][8 * addr[1:0] +: 8]  = b[7:0];
                            2'b01:   ram[idx][8 * addr[1:0] +: 16] = b[15:0];
                            default: ram[idx] = b;
                        endcase
                    end
                end
                default: want.illegal = 1'b1;
            endcase
        end
        want.writeEn = want.writeEn && !want.illegal && (want.rd != 5'd0);
        if (want.writeEn)
            regs[want.rd] = want.data;
        pc = pc + 32'd4;    // Counts illegal ones as well
    endtask

    task automatic reportMismatch(input string name, input string field,
                                  input dataWord want, input dataWord got);
        $display("FAILED %s %s expected %h actual %h", name, field, want, got);
        errors++;
    endtask

    task automatic endRun();
        $display("Checks done: %0d errors, %0d pushed, %0d retired, %0d credits returned",
                 errors, pushes, retired, creditPulses);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    endtask

    task automatic idleCycles(input int n);
        repeat (n)
        begin
            @(negedge clk);
            instrValid = 1'b0;
        end
    endtask

    // Waits for a credit, then drives the word for one cycle
    task automatic pushWord(input instrWord w);
        int waited;
        waited = 0;
        @(negedge clk);
        while ((credits == 0) && (waited < 100))
        begin
            instrValid = 1'b0;
            waited++;
            @(negedge clk);
        end
        if (credits == 0)
        begin
            $display("Timeout: no credit came back within 100 cycles");
            errors++;
            endRun();
        end
        else
        begin
            instrValid = 1'b1;
            instrData  = w;
            credits--;
            pushes++;
            pending.push_back(w);
        end
    endtask

    always @(posedge clk)
    begin
        retireInfo want;
        instrWord  w;
        if (arstN)
        begin
            if ((pushes == 0) && (retireValid || creditReturn))
            begin
                $display("Core output went active before any instruction was pushed");
                errors++;
            end
            if (creditReturn)
            begin
                credits++;
                creditPulses++;
            end
            if ((credits < 0) || (credits > defaultQueueDepth))
            begin
                $display("Source credit count left its range: %0d", credits);
                errors++;
            end
            if (retireValid && (pending.size() == 0))
            begin
                $display("Retire record with no instruction pending");
                errors++;
            end
            else if (retireValid)
            begin
                retired++;
                w = pending.pop_front();
                modelExecute(w, want);
                if (retire.rd != want.rd)
                    reportMismatch(instrKind(w), "rd", 32'(want.rd), 32'(retire.rd));
                if (retire.illegal != want.illegal)
                    reportMismatch(instrKind(w), "illegal",
                                   32'(want.illegal), 32'(retire.illegal));
                if (retire.writeEn != want.writeEn)
                    reportMismatch(instrKind(w), "writeEn",
                                   32'(want.writeEn), 32'(retire.writeEn));
                if (want.writeEn && (retire.data != want.data))
                    reportMismatch(instrKind(w), "data", want.data, retire.data);
            end
        end
    end

    initial
    begin
        int waited;
        seed         = 87165;
        errors       = 0;
        credits      = defaultQueueDepth;
        pushes       = 0;
        retired      = 0;
        creditPulses = 0;
        pc           = defaultResetPc;
        clk          = 1'b0;
        arstN        = 1'b0;
        instrValid   = 1'b0;
        instrData    = '0;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        for (int i = 0; i < defaultRamWords; i++)
            ram[i] = '0;

        repeat (3) @(negedge clk);
        arstN = 1'b1;
        idleCycles(12);    // Outputs must stay quiet

        // x1 ends up with bytes of both signs
        pushWord(encU(20'h8F7E6, 5'd1, opLui));
        pushWord(encI(12'h9A5, 5'd1, 3'b000, 5'd1, opImm));
        pushWord(encS(12'd16, 5'd1, 5'd0, 3'b010));
        pushWord(encS(12'd22, 5'd1, 5'd0, 3'b001));
        pushWord(encS(12'd25, 5'd1, 5'd0, 3'b000));
        pushWord(encS(12'd21, 5'd1, 5'd0, 3'b010));    // Misaligned so it writes nothing
        pushWord(encI(12'd16, 5'd0, 3'b000, 5'd2, opLoad));
        pushWord(encI(12'd19, 5'd0, 3'b100, 5'd3, opLoad));
        pushWord(encI(12'd18, 5'd0, 3'b001, 5'd4, opLoad));
        pushWord(encI(12'd18, 5'd0, 3'b101, 5'd5, opLoad));
        pushWord(encI(12'd20, 5'd0, 3'b010, 5'd6, opLoad));
        pushWord(encI(12'd24, 5'd0, 3'b010, 5'd7, opLoad));

        for (int i = 0; i < 400; i++)
        begin
            if (pick(4) == 0)
                idleCycles(1 + pick(3));
            else
                pushWord(genInstr());
        end
        for (int i = 0; i < 40; i++)
            pushWord(genInstr());    // Back to back until credits run out
        idleCycles(1);

        waited = 0;
        while ((retired < pushes) && (waited < 200))
        begin
            @(negedge clk);
            waited++;
        end
        if (retired < pushes)
        begin
            $display("Timeout: %0d of %0d instructions retired", retired, pushes);
            errors++;
        end
        else
        begin
            idleCycles(2);
            if (creditPulses != retired)
                reportMismatch("credit return", "pulses", 32'(retired), 32'(creditPulses));
            if (credits != defaultQueueDepth)
                reportMismatch("credit return", "credits",
                               32'(defaultQueueDepth), 32'(credits));
        end
        endRun();
    end

endmodule

//--- verilog/instrDecoder.sv
`timescale 1ns/10ps

module instrDecoder
(
    input  rvPkg::instrWord    instr,
    output rvPkg::decodedInstr dec
);
    import rvPkg::*;

    // Standard RV32 field layout
    typedef struct packed {
        logic [6:0] funct7;
        regAddr     rs2;
        regAddr     rs1;
        logic [2:0] funct3;
        regAddr     rd;
        logic [4:0] opField;
        logic [1:0] lowBits;    // Always 11 for 32-bit encodings
    } instrFields;

    instrFields fields;
    aluCtrl     aluSel;
    logic       isRegOp;
    logic       writesRd;

    assign fields  = instrFields'(instr);
    assign isRegOp = (fields.opField == OP);

    // Bit 30 picks SUB only for OP, SRA for both
    always_comb
    begin
        case (fields.funct3)
            3'b000:  aluSel = (isRegOp && fields.funct7[5]) ? SUB : ADD;
            3'b001:  aluSel = SLL;
            3'b010:  aluSel = SLT;
            3'b011:  aluSel = SLTU;
            3'b100:  aluSel = XOR;
            3'b101:  aluSel = fields.funct7[5] ? SRA : SRL;
            3'b110:  aluSel = OR;
            default: aluSel = AND;
        endcase
    end

    always_comb
    begin
        dec            = '0;
        writesRd       = 1'b0;
        dec.op         = opCode'(fields.opField);
        dec.alu        = ADD;
        dec.rs1        = fields.rs1;
        dec.rs2        = fields.rs2;
        dec.rd         = fields.rd;
        dec.loadSigned = ~fields.funct3[2];    // LBU and LHU set bit 2
        dec.width      = lsWidth'(fields.funct3[1:0]);
        dec.useImm     = 1'b1;

        case (dec.op)
            LOAD:
            begin
                dec.imm     = {{20{fields.funct7[6]}}, fields.funct7, fields.rs2};
                dec.isLoad  = 1'b1;
                writesRd    = 1'b1;
                dec.illegal = (dec.width == ERRVAL) || (fields.funct3 == 3'b110);
            end
            STORE:
            begin
                dec.imm     = {{20{fields.funct7[6]}}, fields.funct7, fields.rd};
                dec.isStore = 1'b1;
                dec.illegal = (dec.width == ERRVAL) || fields.funct3[2];
            end
            OP_IMM:
            begin
                dec.imm  = {{20{fields.funct7[6]}}, fields.funct7, fields.rs2};
                dec.alu  = aluSel;
                writesRd = 1'b1;
            end
            OP:
            begin
                dec.useImm = 1'b0;
                dec.alu    = aluSel;
                writesRd   = 1'b1;
            end
            LUI, AUIPC:
            begin
                dec.imm  = {instr[31:12], 12'h000};
                writesRd = 1'b1;
            end
            default: dec.illegal = 1'b1;    // Branches, jumps, system, unknown
        endcase

        if (fields.lowBits != 2'b11)
            dec.illegal = 1'b1;

        dec.regWrite = writesRd && !dec.illegal && (fields.rd != '0);
    end

endmodule

//--- verilog/instrQueue.sv
`timescale 1ns/10ps

module instrQueue
#(
    parameter int Depth = rvPkg::defaultQueueDepth
)
(
    input  logic            clk,
    input  logic            arstN,
    input  logic            push,
    input  rvPkg::instrWord pushData,
    input  logic            pop,
    output rvPkg::instrWord headData,
    output logic            notEmpty,
    output logic            creditReturn
);
    import rvPkg::*;

    localparam int PtrBits = (Depth > 1) ? $clog2(Depth) : 1;

    instrWord           mem [Depth];
    logic [PtrBits-1:0] rdPtr;
    logic [PtrBits-1:0] wrPtr;
    logic [PtrBits:0]   count;    // Occupancy, up to Depth
    logic               popOk;

    function automatic logic [PtrBits-1:0] nextPtr(input logic [PtrBits-1:0] ptr);
        return (ptr == PtrBits'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign notEmpty = (count != '0);
    assign popOk    = pop && notEmpty;
    assign headData = mem[rdPtr];

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wrPtr] <= pushData;
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            rdPtr        <= '0;
            wrPtr        <= '0;
            count        <= '0;
            creditReturn <= 1'b0;
        end
        else
        begin
            if (push)
                wrPtr <= nextPtr(wrPtr);
            if (popOk)
                rdPtr <= nextPtr(rdPtr);
            case ({push, popOk})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            creditReturn <= popOk;    // One credit back per freed entry
        end
    end

endmodule

//--- verilog/regFile.sv
`timescale 1ns/10ps

module regFile
(
    input  logic           clk,
    input  logic           arstN,
    input  rvPkg::regAddr  rs1,
    input  rvPkg::regAddr  rs2,
    input  rvPkg::regAddr  rd,
    input  logic           writeEn,
    input  rvPkg::dataWord writeData,
    output rvPkg::dataWord rs1Data,
    output rvPkg::dataWord rs2Data
);
    import rvPkg::*;

    dataWord regs [32];

    // Entry 0 is never written, so x0 reads back zero
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (writeEn && (rd != '0))
        begin
            regs[rd] <= writeData;
        end
    end

    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

endmodule

//--- verilog/rvExecCore.sv
`timescale 1ns/10ps

module rvExecCore
#(
    parameter int             QueueDepth = rvPkg::defaultQueueDepth,
    parameter int             RamWords   = rvPkg::defaultRamWords,
    parameter rvPkg::dataWord ResetPc    = rvPkg::defaultResetPc
)
(
    input  logic             clk,
    input  logic             arstN,
    input  logic             instrValid,
    input  rvPkg::instrWord  instrData,
    output logic             creditReturn,
    output logic             retireValid,
    output rvPkg::retireInfo retire
);
    import rvPkg::*;

    instrWord    headWord;
    logic        notEmpty;
    logic        issue;
    decodedInstr dec;
    dataWord     rs1Data;
    dataWord     rs2Data;
    dataWord     opA;
    dataWord     opB;
    dataWord     aluResult;
    dataWord     loadData;
    dataWord     wbData;
    logic        misaligned;
    logic        illegal;
    logic        rfWriteEn;
    dataWord     pc;
    retireInfo   retireNext;

    assign issue = notEmpty;    // Every instruction completes in one cycle

    instrQueue #(.Depth(QueueDepth)) i_queue
    (
        .clk          (clk),
        .arstN        (arstN),
        .push         (instrValid),
        .pushData     (instrData),
        .pop          (issue),
        .headData     (headWord),
        .notEmpty     (notEmpty),
        .creditReturn (creditReturn)
    );

    instrDecoder i_decoder
    (
        .instr (headWord),
        .dec   (dec)
    );

    regFile i_regFile
    (
        .clk       (clk),
        .arstN     (arstN),
        .rs1       (dec.rs1),
        .rs2       (dec.rs2),
        .rd        (dec.rd),
        .writeEn   (rfWriteEn),
        .writeData (wbData),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data)
    );

    always_comb
    begin
        case (dec.op)
            AUIPC:   opA = pc;
            LUI:     opA = '0;
            default: opA = rs1Data;
        endcase
    end

    assign opB = dec.useImm ? dec.imm : rs2Data;

    aluUnit i_alu
    (
        .ctrl   (dec.alu),
        .a      (opA),
        .b      (opB),
        .result (aluResult)
    );

    loadStoreUnit #(.RamWords(RamWords)) i_lsu
    (
        .clk        (clk),
        .arstN      (arstN),
        .addr       (aluResult),    // Base plus offset
        .storeData  (rs2Data),
        .storeEn    (issue && dec.isStore && !dec.illegal),
        .loadSigned (dec.loadSigned),
        .width      (dec.width),
        .loadData   (loadData),
        .misaligned (misaligned)
    );

    // Misalignment only counts for memory accesses
    assign illegal   = dec.illegal || ((dec.isLoad || dec.isStore) && misaligned);
    assign wbData    = dec.isLoad ? loadData : aluResult;
    assign rfWriteEn = issue && dec.regWrite && !illegal;

    assign retireNext.rd      = dec.rd;
    assign retireNext.data    = wbData;
    assign retireNext.writeEn = dec.regWrite && !illegal;
    assign retireNext.illegal = illegal;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            retireValid <= 1'b0;
            pc          <= ResetPc;
        end
        else
        begin
            retireValid <= issue;
            if (issue)
                pc <= pc + 32'd4;    // Advances on illegal ones too
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue)
            retire <= retireNext;
    end

endmodule
